// ==== files.f ====
verilog/ialu_cfg_pkg.sv
verilog/ialu_cmd_pkg.sv
verilog/ialu_in_stage.sv
verilog/ialu_sum_cmp.sv
verilog/ialu_shift_logic.sv
verilog/ialu_out_stage.sv
verilog/ialu_top.sv
tb/ialu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ALU testbench with Verilator, pass is decided from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f files.f --top-module ialu_tb -o ialu_sim \
    && ./obj_dir/ialu_sim | tee sim.log

grep -qx "Test passed" sim.log && exit 0 || exit 1

// ==== tb/ialu_tb.sv ====
//----------------------------------------------------------
// Testbench for the two-stage ALU, vectors read from file
// Random input gaps and consumer stalls, in-order checking
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ialu_tb;

    localparam int MAX_VEC  = 64;  // Room in the vector memory
    localparam int VEC_COLS = 5;   // cmd, op1, op2, exp_res, exp_cmp
    localparam int DRAIN    = 5;   // Idle cycles watched after the last result

    // DUT ports
    logic                     clk;
    logic                     rst_n;
    logic                     cmd_valid_i;
    logic                     cmd_ready_o;
    ialu_cmd_pkg::ialu_cmd_e  cmd_i;
    ialu_cfg_pkg::ialu_word_t op1_i;
    ialu_cfg_pkg::ialu_word_t op2_i;
    logic                     res_valid_o;
    logic                     res_ready_i;
    ialu_cfg_pkg::ialu_word_t res_o;
    logic                     cmp_o;

    // Raw file words and decoded vectors
    logic [ialu_cfg_pkg::XLEN-1:0] vec_mem [0:MAX_VEC*VEC_COLS-1];
    ialu_cmd_pkg::ialu_cmd_e       vec_cmd [0:MAX_VEC-1];
    ialu_cfg_pkg::ialu_word_t      vec_op1 [0:MAX_VEC-1];
    ialu_cfg_pkg::ialu_word_t      vec_op2 [0:MAX_VEC-1];
    ialu_cfg_pkg::ialu_word_t      vec_res [0:MAX_VEC-1];
    logic                          vec_cmp [0:MAX_VEC-1];

    int     num_vec     = 0;
    int     sent        = 0;   // Commands accepted by the DUT
    int     taken       = 0;   // Results taken from the DUT
    int     extra       = 0;   // Results seen after the last vector
    int     cycle_cnt   = 0;
    int     cycle_limit = 0;
    integer seed        = 53;
    logic   holding;           // Command still waiting for ready
    logic   marker_found;

    ialu_top u_ialu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_i       (cmd_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o),
        .cmp_o       (cmp_o)
    );

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    //----------------------------------------------------------
    // Failure reporting and compare tasks
    //----------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_res(input string name, input ialu_cfg_pkg::ialu_word_t exp,
                             input ialu_cfg_pkg::ialu_word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s expected %h got %h at result %0d",
                                    name, exp, act, taken));
        end
    endtask

    task automatic check_cmp(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s expected %h got %h at result %0d",
                                    name, exp, act, taken));
        end
    endtask

    //----------------------------------------------------------
    // Vector loading
    //----------------------------------------------------------
    task automatic load_vectors();
        int base;
        marker_found = 1'b0;
        $readmemh("tb/ialu_vectors.txt", vec_mem);
        for (int i = 0; i < MAX_VEC; i++) begin
            base = i * VEC_COLS;
            if (!marker_found) begin
                if (vec_mem[base] == 32'hf) begin
                    marker_found = 1'b1;     // End of list
                    num_vec      = i;
                end else begin
                    vec_cmd[i] = ialu_cmd_pkg::ialu_cmd_e'(vec_mem[base][3:0]);
                    vec_op1[i] = vec_mem[base+1];
                    vec_op2[i] = vec_mem[base+2];
                    vec_res[i] = vec_mem[base+3];
                    vec_cmp[i] = vec_mem[base+4][0];
                end
            end
        end
        if (!marker_found || num_vec == 0) begin
            stop_on_error("vector file has no end marker or no vectors");
        end
    endtask

    // Put one vector on the command port
    task automatic drive_vector(input int idx);
        cmd_valid_i = 1'b1;
        cmd_i       = vec_cmd[idx];
        op1_i       = vec_op1[idx];
        op2_i       = vec_op2[idx];
    endtask

    //----------------------------------------------------------
    // Timeout
    //----------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_on_error("results did not arrive in time");
        end
    end

    //----------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = ialu_cmd_pkg::ADD;
        op1_i       = '0;
        op2_i       = '0;
        res_ready_i = 1'b0;
        holding     = 1'b0;

        load_vectors();
        cycle_limit = num_vec * 8 + 50;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;               // Released on a falling edge
        #1;
        check_cmp("res_valid_o", 1'b0, res_valid_o);
        check_cmp("cmd_ready_o", 1'b1, cmd_ready_o);

        while (taken < num_vec) begin
            @(negedge clk);
            res_ready_i = ({$random(seed)} % 3) != 0;  // Stall about 1 in 3
            if (!holding) begin
                if (sent < num_vec && ({$random(seed)} % 4) != 0) begin
                    drive_vector(sent);
                end else begin
                    cmd_valid_i = 1'b0;     // Idle gap, operands are junk
                    op1_i       = $random(seed);
                    op2_i       = $random(seed);
                end
            end
            #1;                             // Let the ready paths settle

            // Result taken at the coming edge
            if (res_valid_o && res_ready_i) begin
                if (taken >= sent) begin
                    stop_on_error("result appeared with no accepted command left");
                end
                check_res("res_o", vec_res[taken], res_o);
                check_cmp("cmp_o", vec_cmp[taken], cmp_o);
                taken++;
            end

            // Command accepted at the coming edge
            if (cmd_valid_i && cmd_ready_o) begin
                sent++;
            end
            holding = cmd_valid_i && !cmd_ready_o;
        end

        // No further result may show up
        repeat (DRAIN) begin
            @(negedge clk);
            cmd_valid_i = 1'b0;
            res_ready_i = 1'b1;
            #1;
            if (res_valid_o) begin
                extra++;
            end
        end

        if (extra == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_on_error("extra result appeared after the last vector");
        end
    end

endmodule

`default_nettype wire

// ==== tb/ialu_vectors.txt ====
// cmd op1 op2 exp_res exp_cmp, all hex, one operation per line
// cmd 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 SLL 6 SRL 7 SRA 8 LT 9 LTU a EQ b NE c GE d GEU, f ends
0 00000005 00000003 00000008 0
0 ffffffff 00000001 00000000 0
0 7fffffff 00000001 80000000 0
0 89abcdef 76543210 ffffffff 0
1 00000003 00000005 fffffffe 0
1 80000000 00000001 7fffffff 0
1 12345678 12345678 00000000 0
8 80000000 00000001 00000001 1
9 80000000 00000001 00000000 0
8 7fffffff 80000000 00000000 0
9 7fffffff 80000000 00000001 1
8 ffffffff 00000000 00000001 1
c 00000001 80000000 00000001 1
d 00000001 80000000 00000000 0
a deadbeef deadbeef 00000001 1
b deadbeef deadbeee 00000001 1
a 00000000 00000001 00000000 0
c 80000000 80000000 00000001 1
d ffffffff fffffffe 00000001 1
2 f0f0a5a5 ff00ff00 f000a500 0
3 f0f0a5a5 0f0f0000 ffffa5a5 0
4 aaaaaaaa ffff0000 5555aaaa 0
5 00000001 0000001f 80000000 0
5 12345678 00000000 12345678 0
6 80000000 0000001f 00000001 0
7 80000000 0000001f ffffffff 0
7 f0000000 00000024 ff000000 0
6 f0000000 ffffffe4 0f000000 0
5 0000000f 00000fe8 00000f00 0
7 7ffffff0 00000004 07ffffff 0
f 00000000 00000000 00000000 0

// ==== verilog/ialu_cfg_pkg.sv ====
//----------------------------------------------------------
// Datapath widths and the data word type of the ALU
//----------------------------------------------------------

`default_nettype none

package ialu_cfg_pkg;

    //----------------------------------------------------------
    // Widths
    //----------------------------------------------------------

    localparam int XLEN    = 32;  // Data word width
    localparam int SHAMT_W = 5;   // Shift amount bits taken from op2

    //----------------------------------------------------------
    // Types
    //----------------------------------------------------------

    // One data word, operands and results alike
    typedef logic [XLEN-1:0] ialu_word_t;

endpackage

`default_nettype wire

// ==== verilog/ialu_cmd_pkg.sv ====
//----------------------------------------------------------
// Command opcodes of the ALU and the command class helpers
//----------------------------------------------------------

`default_nettype none

package ialu_cmd_pkg;

    // Opcode numbers are fixed, vectors carry them as plain numbers
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SRA = 4'd7,
        LT  = 4'd8,    // Signed less than
        LTU = 4'd9,    // Unsigned less than
        EQ  = 4'd10,
        NE  = 4'd11,
        GE  = 4'd12,   // Signed greater or equal
        GEU = 4'd13    // Unsigned greater or equal
    } ialu_cmd_e;

    // Sum result commands
    function automatic logic is_arith(ialu_cmd_e cmd);
        return (cmd == ADD) || (cmd == SUB);
    endfunction

    // Compare commands, result is a one-bit flag
    function automatic logic is_cmp(ialu_cmd_e cmd);
        return cmd inside {LT, LTU, EQ, NE, GE, GEU};
    endfunction

    function automatic logic is_logic(ialu_cmd_e cmd);
        return cmd inside {AND, OR, XOR};
    endfunction

    function automatic logic is_shift(ialu_cmd_e cmd);
        return cmd inside {SLL, SRL, SRA};
    endfunction

endpackage

`default_nettype wire

// ==== verilog/ialu_in_stage.sv ====
//----------------------------------------------------------
// Input pipeline register for command and operands
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ialu_in_stage (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    // Producer side
    input  wire logic                    cmd_valid_i,
    output logic                         cmd_ready_o,
    input  wire ialu_cmd_pkg::ialu_cmd_e cmd_i,
    input  wire ialu_cfg_pkg::ialu_word_t op1_i,
    input  wire ialu_cfg_pkg::ialu_word_t op2_i,
    // Towards the units and the output stage
    input  wire logic                    s1_ready_i,
    output logic                         s1_valid_o,
    output ialu_cmd_pkg::ialu_cmd_e      s1_cmd_o,
    output ialu_cfg_pkg::ialu_word_t     s1_op1_o,
    output ialu_cfg_pkg::ialu_word_t     s1_op2_o
);

    logic load;  // Accept from producer this cycle

    // Free slot, or the entry leaves at this edge
    assign cmd_ready_o = ~s1_valid_o | s1_ready_i;
    assign load        = cmd_valid_i & cmd_ready_o;

    //----------------------------------------------------------
    // Valid flag
    //----------------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            s1_valid_o <= 1'b0;
        end else if (load) begin
            s1_valid_o <= 1'b1;
        end else if (s1_ready_i) begin
            s1_valid_o <= 1'b0;       // Entry taken downstream
        end
    end

    // Payload, loaded only on accept
    always_ff @(posedge clk) begin
        if (load) begin
            s1_cmd_o <= cmd_i;
            s1_op1_o <= op1_i;
            s1_op2_o <= op2_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ialu_out_stage.sv ====
//----------------------------------------------------------
// Result merge and output register with back-pressure
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ialu_out_stage (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // From the input stage
    input  wire logic                     s1_valid_i,
    output logic                          s1_ready_o,
    // Unit results, zero when not their class
    input  wire ialu_cfg_pkg::ialu_word_t sum_i,
    input  wire logic                     cmp_i,
    input  wire ialu_cfg_pkg::ialu_word_t sl_i,
    // Consumer side
    input  wire logic                     res_ready_i,
    output logic                          res_valid_o,
    output ialu_cfg_pkg::ialu_word_t      res_o,
    output logic                          cmp_o
);

    ialu_cfg_pkg::ialu_word_t merged;  // Combined unit result
    logic                     load;

    //----------------------------------------------------------
    // Merge
    //----------------------------------------------------------

    // Only one unit is nonzero for any command
    assign merged = sum_i | sl_i;

    //----------------------------------------------------------
    // Handshake
    //----------------------------------------------------------

    // Register empty, or its result is taken at this edge
    assign s1_ready_o = ~res_valid_o | res_ready_i;
    assign load       = s1_valid_i & s1_ready_o;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            res_valid_o <= 1'b0;
        end else if (s1_ready_o) begin
            res_valid_o <= s1_valid_i;  // Refill or drain
        end
    end

    //----------------------------------------------------------
    // Output register
    //----------------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            res_o <= '0;
            cmp_o <= 1'b0;
        end else if (load) begin
            res_o <= merged;
            cmp_o <= cmp_i;
        end
        // Held while consumer stalls
    end

endmodule

`default_nettype wire

// ==== verilog/ialu_shift_logic.sv ====
//----------------------------------------------------------
// Barrel shifter and bitwise logic operations
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ialu_shift_logic (
    input  wire ialu_cmd_pkg::ialu_cmd_e  cmd_i,
    input  wire ialu_cfg_pkg::ialu_word_t op1_i,
    input  wire ialu_cfg_pkg::ialu_word_t op2_i,
    output ialu_cfg_pkg::ialu_word_t      res_o
);

    logic [ialu_cfg_pkg::SHAMT_W-1:0] shamt;      // Upper op2 bits ignored
    ialu_cfg_pkg::ialu_word_t         logic_res;
    ialu_cfg_pkg::ialu_word_t         shft_res;

    assign shamt = op2_i[ialu_cfg_pkg::SHAMT_W-1:0];

    //----------------------------------------------------------
    // Bitwise logic
    //----------------------------------------------------------
    always_comb begin
        case (cmd_i)
            ialu_cmd_pkg::AND : logic_res = op1_i & op2_i;
            ialu_cmd_pkg::OR  : logic_res = op1_i | op2_i;
            default           : logic_res = op1_i ^ op2_i;  // XOR
        endcase
    end

    //----------------------------------------------------------
    // Shifter
    //----------------------------------------------------------
    always_comb begin
        case (cmd_i)
            ialu_cmd_pkg::SRL : shft_res = op1_i >> shamt;
            ialu_cmd_pkg::SRA : shft_res = $signed(op1_i) >>> shamt;  // Sign fill
            default           : shft_res = op1_i << shamt;            // SLL
        endcase
    end

    // Zero for adder and compare commands
    assign res_o = ialu_cmd_pkg::is_logic(cmd_i) ? logic_res :
                   ialu_cmd_pkg::is_shift(cmd_i) ? shft_res  : '0;

endmodule

`default_nettype wire

// ==== verilog/ialu_sum_cmp.sv ====
//----------------------------------------------------------
// Main adder with its flags and the compare outcomes
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ialu_sum_cmp (
    input  wire ialu_cmd_pkg::ialu_cmd_e  cmd_i,
    input  wire ialu_cfg_pkg::ialu_word_t op1_i,
    input  wire ialu_cfg_pkg::ialu_word_t op2_i,
    output ialu_cfg_pkg::ialu_word_t      sum_o,
    output logic                          cmp_o
);

    logic [ialu_cfg_pkg::XLEN:0] sum_res;  // Extra top bit is carry
    logic                        do_add;
    logic                        flag_c;
    logic                        flag_z;
    logic                        flag_s;
    logic                        flag_o;
    logic                        cmp_res;

    //----------------------------------------------------------
    // Main adder
    //----------------------------------------------------------
    assign do_add = (cmd_i == ialu_cmd_pkg::ADD);  // Everything else subtracts

    // Zero-extended operands, carry lands in the top bit
    assign sum_res = do_add ? ({1'b0, op1_i} + {1'b0, op2_i})
                            : ({1'b0, op1_i} - {1'b0, op2_i});

    assign flag_c = sum_res[ialu_cfg_pkg::XLEN];        // Borrow on subtract
    assign flag_z = ~|sum_res[ialu_cfg_pkg::XLEN-1:0];
    assign flag_s = sum_res[ialu_cfg_pkg::XLEN-1];

    // Overflow when result sign differs from op1 and the operand signs allow it
    assign flag_o = (op1_i[ialu_cfg_pkg::XLEN-1] ^ flag_s)
                  & (op1_i[ialu_cfg_pkg::XLEN-1] ^ op2_i[ialu_cfg_pkg::XLEN-1] ^ do_add);

    //----------------------------------------------------------
    // Compare outcomes
    //----------------------------------------------------------
    always_comb begin
        case (cmd_i)
            ialu_cmd_pkg::LT  : cmp_res = flag_s ^ flag_o;
            ialu_cmd_pkg::LTU : cmp_res = flag_c;
            ialu_cmd_pkg::EQ  : cmp_res = flag_z;
            ialu_cmd_pkg::NE  : cmp_res = ~flag_z;
            ialu_cmd_pkg::GE  : cmp_res = ~(flag_s ^ flag_o);
            ialu_cmd_pkg::GEU : cmp_res = ~flag_c;
            default           : cmp_res = 1'b0;
        endcase
    end

    // Zero outside own command class so the merge can OR
    always_comb begin
        if (ialu_cmd_pkg::is_arith(cmd_i)) begin
            sum_o = sum_res[ialu_cfg_pkg::XLEN-1:0];
            cmp_o = 1'b0;
        end else if (ialu_cmd_pkg::is_cmp(cmd_i)) begin
            sum_o = ialu_cfg_pkg::ialu_word_t'(cmp_res);  // Zero-extended flag
            cmp_o = cmp_res;
        end else begin
            sum_o = '0;
            cmp_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ialu_top.sv ====
//----------------------------------------------------------
// Two-stage ALU top, stages and units wired together
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ialu_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // Command side
    input  wire logic                     cmd_valid_i,
    output logic                          cmd_ready_o,
    input  wire ialu_cmd_pkg::ialu_cmd_e  cmd_i,
    input  wire ialu_cfg_pkg::ialu_word_t op1_i,
    input  wire ialu_cfg_pkg::ialu_word_t op2_i,
    // Result side
    output logic                          res_valid_o,
    input  wire logic                     res_ready_i,
    output ialu_cfg_pkg::ialu_word_t      res_o,
    output logic                          cmp_o
);

    // Stage 1 entry
    logic                     s1_valid;
    logic                     s1_ready;
    ialu_cmd_pkg::ialu_cmd_e  s1_cmd;
    ialu_cfg_pkg::ialu_word_t s1_op1;
    ialu_cfg_pkg::ialu_word_t s1_op2;

    // Unit outputs
    ialu_cfg_pkg::ialu_word_t sum_res;
    logic                     sum_cmp;
    ialu_cfg_pkg::ialu_word_t sl_res;

    ialu_in_stage u_in_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_i       (cmd_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .s1_ready_i  (s1_ready),
        .s1_valid_o  (s1_valid),
        .s1_cmd_o    (s1_cmd),
        .s1_op1_o    (s1_op1),
        .s1_op2_o    (s1_op2)
    );

    //----------------------------------------------------------
    // Units, combinational between the stages
    //----------------------------------------------------------
    ialu_sum_cmp u_sum_cmp (
        .cmd_i (s1_cmd),
        .op1_i (s1_op1),
        .op2_i (s1_op2),
        .sum_o (sum_res),
        .cmp_o (sum_cmp)
    );

    ialu_shift_logic u_shift_logic (
        .cmd_i (s1_cmd),
        .op1_i (s1_op1),
        .op2_i (s1_op2),
        .res_o (sl_res)
    );

    ialu_out_stage u_out_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .s1_valid_i  (s1_valid),
        .s1_ready_o  (s1_ready),
        .sum_i       (sum_res),
        .cmp_i       (sum_cmp),
        .sl_i        (sl_res),
        .res_ready_i (res_ready_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .cmp_o       (cmp_o)
    );

endmodule

`default_nettype wire
